/* common/link_io_pkg.sv */
package link_io_pkg;

	//////////////////////////////////////////////////
	// Link count and register map
	//////////////////////////////////////////////////

	localparam int num_links      = 4;
	localparam int words_per_link = 4;
	localparam int ce_width       = (num_links + 1) * words_per_link;
	localparam int global_base    = num_links * words_per_link;
	localparam int bus_width      = 32;

	// Word offsets inside one link block
	localparam int reg_ctrl   = 0;
	localparam int reg_slip   = 1;
	localparam int reg_errors = 2;
	localparam int reg_status = 3;

	// Per-link control word
	localparam int bit_delay_set      = 0;
	localparam int bit_train_mode     = 1;
	localparam int bit_reset_counters = 2;
	localparam int bit_link_enable    = 3;
	localparam int bit_bypass         = 4;
	localparam int bit_tristate       = 5;

	// Global control word, word 0 of the spare block
	localparam int bit_global_reset_counters = 0;
	localparam int bit_global_enable         = 1;

	// Status word, slip value sits in the low bits
	localparam int bit_slip_ready = 8;

	//////////////////////////////////////////////////
	// Line word and lane settings
	//////////////////////////////////////////////////

	localparam int slip_width = 3;
	localparam int err_width  = 16;

	typedef logic [7:0] line_word_t;

	localparam line_word_t train_word = 8'hB4;

endpackage

/* common/link_ctrl_if.sv */
interface link_ctrl_if;
	import link_io_pkg::*;

	// Controls from the register block
	logic                  delay_set;
	logic [slip_width-1:0] slip_in;
	logic                  train_mode;
	logic                  reset_counters;
	logic                  link_en;
	logic                  bypass;
	logic                  tristate;

	// Status back from the receive lane
	logic [slip_width-1:0] slip_out;
	logic                  slip_ready;
	logic [err_width-1:0]  align_errors;

	modport regs (
		output delay_set,
		output slip_in,
		output train_mode,
		output reset_counters,
		output link_en,
		output bypass,
		output tristate,
		input  slip_out,
		input  slip_ready,
		input  align_errors
	);

	modport link (
		input  delay_set,
		input  slip_in,
		input  train_mode,
		input  reset_counters,
		input  link_en,
		input  bypass,
		input  tristate,
		output slip_out,
		output slip_ready,
		output align_errors
	);

endinterface

/* regs/link_regs.sv */
module link_regs (
	input  logic                                   in_clk160,
	input  logic                                   rst_n,
	input  logic [link_io_pkg::ce_width-1:0]       bus_wrce,
	input  logic [link_io_pkg::ce_width-1:0]       bus_rdce,
	input  logic [link_io_pkg::bus_width-1:0]      bus_data,
	output logic [link_io_pkg::bus_width-1:0]      bus_rddata,
	output logic                                   bus_wrack,
	output logic                                   bus_rdack,
	link_ctrl_if.regs                              ctrl [link_io_pkg::num_links]
);
	import link_io_pkg::*;

	// Per-link levels and pulses
	logic [num_links-1:0]  train_q;
	logic [num_links-1:0]  link_en_q;
	logic [num_links-1:0]  bypass_q;
	logic [num_links-1:0]  tristate_q;
	logic [num_links-1:0]  delay_set_q;
	logic [num_links-1:0]  rst_cnt_q;
	logic [slip_width-1:0] slip_q [num_links];

	// Spare block, global control
	logic global_en_q;
	logic global_rst_q;

	// Status gathered from the lanes
	logic [slip_width-1:0] slip_out_w [num_links];
	logic [num_links-1:0]  slip_ready_w;
	logic [err_width-1:0]  errors_w [num_links];

	logic [bus_width-1:0] rd_word;

	//////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			train_q      <= '0;
			link_en_q    <= '1;
			bypass_q     <= '0;
			tristate_q   <= '0;
			delay_set_q  <= '0;
			rst_cnt_q    <= '0;
			slip_q       <= '{default: '0};
			global_en_q  <= 1'b1;
			global_rst_q <= 1'b0;
			bus_wrack    <= 1'b0;
			bus_rdack    <= 1'b0;
		end else begin
			// Pulse bits only live for one cycle
			delay_set_q  <= '0;
			rst_cnt_q    <= '0;
			global_rst_q <= 1'b0;
			for (int l = 0; l < num_links; l++) begin
				if (bus_wrce[l*words_per_link + reg_ctrl]) begin
					delay_set_q[l] <= bus_data[bit_delay_set];
					train_q[l]     <= bus_data[bit_train_mode];
					rst_cnt_q[l]   <= bus_data[bit_reset_counters];
					link_en_q[l]   <= bus_data[bit_link_enable];
					bypass_q[l]    <= bus_data[bit_bypass];
					tristate_q[l]  <= bus_data[bit_tristate];
				end
				if (bus_wrce[l*words_per_link + reg_slip]) begin
					slip_q[l] <= bus_data[slip_width-1:0];
				end
			end
			if (bus_wrce[global_base + reg_ctrl]) begin
				global_rst_q <= bus_data[bit_global_reset_counters];
				global_en_q  <= bus_data[bit_global_enable];
			end
			bus_wrack <= |bus_wrce;
			bus_rdack <= |bus_rdce;
		end
	end

	//////////////////////////////////////////////////
	// Control fan-out and status collection
	//////////////////////////////////////////////////

	for (genvar g = 0; g < num_links; g++) begin : g_link
		assign ctrl[g].delay_set      = delay_set_q[g];
		assign ctrl[g].slip_in        = slip_q[g];
		assign ctrl[g].train_mode     = train_q[g];
		// Global pulse and enable fold in here
		assign ctrl[g].reset_counters = rst_cnt_q[g] | global_rst_q;
		assign ctrl[g].link_en        = link_en_q[g] & global_en_q;
		assign ctrl[g].bypass         = bypass_q[g];
		assign ctrl[g].tristate       = tristate_q[g];

		assign slip_out_w[g]   = ctrl[g].slip_out;
		assign slip_ready_w[g] = ctrl[g].slip_ready;
		assign errors_w[g]     = ctrl[g].align_errors;
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	// Enables are one-hot, so at most one word lands here
	always_comb begin
		rd_word = '0;
		for (int l = 0; l < num_links; l++) begin
			if (bus_rdce[l*words_per_link + reg_ctrl]) begin
				rd_word[bit_train_mode]  = train_q[l];
				rd_word[bit_link_enable] = link_en_q[l];
				rd_word[bit_bypass]      = bypass_q[l];
				rd_word[bit_tristate]    = tristate_q[l];
			end
			if (bus_rdce[l*words_per_link + reg_slip]) begin
				rd_word[slip_width-1:0] = slip_q[l];
			end
			if (bus_rdce[l*words_per_link + reg_errors]) begin
				rd_word[err_width-1:0] = errors_w[l];
			end
			if (bus_rdce[l*words_per_link + reg_status]) begin
				rd_word[slip_width-1:0] = slip_out_w[l];
				rd_word[bit_slip_ready] = slip_ready_w[l];
			end
		end
		if (bus_rdce[global_base + reg_ctrl]) begin
			rd_word[bit_global_enable] = global_en_q;
		end
	end

	// Data goes out alongside rdack
	always_ff @(posedge in_clk160) begin
		bus_rddata <= rd_word;
	end

endmodule

/* lane/link_tx.sv */
module link_tx (
	input  logic                    in_clk160,
	input  logic                    rst_n,
	input  link_io_pkg::line_word_t in_tdata,
	input  logic                    in_tvalid,
	output link_io_pkg::line_word_t line_data,
	output logic                    line_en,
	link_ctrl_if.link               ctrl
);
	import link_io_pkg::*;

	line_word_t tx_data_q;
	logic       tx_valid_q;

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	// Stands in for the serializer input stage
	always_ff @(posedge in_clk160) begin
		tx_data_q <= in_tdata;
	end

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			tx_valid_q <= 1'b0;
		end else begin
			tx_valid_q <= in_tvalid;
		end
	end

	//////////////////////////////////////////////////
	// Line drive
	//////////////////////////////////////////////////

	assign line_data = tx_data_q;

	// Driver off with no valid word, or when the link is tristated
	assign line_en = tx_valid_q & ~ctrl.tristate;

endmodule

/* lane/link_rx.sv */
module link_rx (
	input  logic                    in_clk160,
	input  logic                    rst_n,
	input  link_io_pkg::line_word_t tx_tdata,
	input  logic                    tx_tvalid,
	input  link_io_pkg::line_word_t line_in,
	input  logic                    line_in_en,
	output link_io_pkg::line_word_t out_tdata,
	output logic                    out_tvalid,
	link_ctrl_if.link               ctrl
);
	import link_io_pkg::*;

	logic [slip_width-1:0] slip_q;
	logic                  slip_ready_q;
	logic [15:0]           rot_ext;
	line_word_t            rx_word;
	line_word_t            rx_data_q;
	logic                  rx_valid_q;
	logic [err_width-1:0]  err_q;

	line_word_t byp_data_q [2];
	logic [1:0] byp_valid_q;

	//////////////////////////////////////////////////
	// Bit-slip, the delay stand-in
	//////////////////////////////////////////////////

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			slip_q       <= '0;
			slip_ready_q <= 1'b0;
		end else if (ctrl.delay_set) begin
			slip_q       <= ctrl.slip_in;
			slip_ready_q <= 1'b1;
		end
	end

	// Upper half of the doubled word is the left rotation
	assign rot_ext = {line_in, line_in} << slip_q;
	assign rx_word = rot_ext[15:8];

	always_ff @(posedge in_clk160) begin
		rx_data_q <= ctrl.link_en ? rx_word : '0;
	end

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			rx_valid_q <= 1'b0;
		end else begin
			rx_valid_q <= line_in_en & ctrl.link_en;
		end
	end

	//////////////////////////////////////////////////
	// Training error count
	//////////////////////////////////////////////////

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			err_q <= '0;
		end else if (ctrl.reset_counters) begin
			err_q <= '0;
		end else if (ctrl.train_mode && rx_valid_q && rx_data_q != train_word) begin
			// Saturates at all ones
			if (err_q != '1) begin
				err_q <= err_q + 1'b1;
			end
		end
	end

	assign ctrl.slip_out     = slip_q;
	assign ctrl.slip_ready   = slip_ready_q;
	assign ctrl.align_errors = err_q;

	//////////////////////////////////////////////////
	// Bypass delay and output select
	//////////////////////////////////////////////////

	always_ff @(posedge in_clk160) begin
		byp_data_q[0] <= tx_tdata;
		byp_data_q[1] <= ctrl.link_en ? byp_data_q[0] : '0;
	end

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			byp_valid_q <= '0;
		end else begin
			byp_valid_q[0] <= tx_tvalid;
			byp_valid_q[1] <= byp_valid_q[0] & ctrl.link_en;
		end
	end

	assign out_tdata  = ctrl.bypass ? byp_data_q[1] : rx_data_q;
	assign out_tvalid = ctrl.bypass ? byp_valid_q[1] : rx_valid_q;

endmodule

/* src/link_io_top.sv */
module link_io_top (
	input  logic                                                in_clk160,
	input  logic                                                rst_n,

	// Stream side, one word per link per cycle
	input  link_io_pkg::line_word_t [link_io_pkg::num_links-1:0] in_tdata,
	input  logic [link_io_pkg::num_links-1:0]                    in_tvalid,
	output link_io_pkg::line_word_t [link_io_pkg::num_links-1:0] out_tdata,
	output logic [link_io_pkg::num_links-1:0]                    out_tvalid,

	// Line side
	output link_io_pkg::line_word_t [link_io_pkg::num_links-1:0] line_data,
	output logic [link_io_pkg::num_links-1:0]                    line_en,
	input  link_io_pkg::line_word_t [link_io_pkg::num_links-1:0] line_in,
	input  logic [link_io_pkg::num_links-1:0]                    line_in_en,

	// Register bus
	input  logic [link_io_pkg::ce_width-1:0]                     bus_wrce,
	input  logic [link_io_pkg::ce_width-1:0]                     bus_rdce,
	input  logic [link_io_pkg::bus_width-1:0]                    bus_data,
	output logic [link_io_pkg::bus_width-1:0]                    bus_rddata,
	output logic                                                bus_wrack,
	output logic                                                bus_rdack
);
	import link_io_pkg::*;

	link_ctrl_if ctrl [num_links] ();

	//////////////////////////////////////////////////
	// Register block
	//////////////////////////////////////////////////

	link_regs u_regs (
		.in_clk160  (in_clk160),
		.rst_n      (rst_n),
		.bus_wrce   (bus_wrce),
		.bus_rdce   (bus_rdce),
		.bus_data   (bus_data),
		.bus_rddata (bus_rddata),
		.bus_wrack  (bus_wrack),
		.bus_rdack  (bus_rdack),
		.ctrl       (ctrl)
	);

	//////////////////////////////////////////////////
	// Per-link lanes
	//////////////////////////////////////////////////

	for (genvar i = 0; i < num_links; i++) begin : g_lane
		link_tx u_tx (
			.in_clk160 (in_clk160),
			.rst_n     (rst_n),
			.in_tdata  (in_tdata[i]),
			.in_tvalid (in_tvalid[i]),
			.line_data (line_data[i]),
			.line_en   (line_en[i]),
			.ctrl      (ctrl[i])
		);

		// Bypass taps the word before the line
		link_rx u_rx (
			.in_clk160  (in_clk160),
			.rst_n      (rst_n),
			.tx_tdata   (in_tdata[i]),
			.tx_tvalid  (in_tvalid[i]),
			.line_in    (line_in[i]),
			.line_in_en (line_in_en[i]),
			.out_tdata  (out_tdata[i]),
			.out_tvalid (out_tvalid[i]),
			.ctrl       (ctrl[i])
		);
	end

endmodule

/* test/link_io_sva.sv */
module link_io_sva (
	input logic                               in_clk160,
	input logic                               rst_n,
	input logic [link_io_pkg::ce_width-1:0]   wrce,
	input logic [link_io_pkg::ce_width-1:0]   rdce,
	input logic                               wrack,
	input logic                               rdack,
	input logic                               tvalid,
	input logic                               line_en,
	input logic                               tristate
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	//////////////////////////////////////////////////
	// Register bus acknowledges
	//////////////////////////////////////////////////

	a_wrack_follows: assert property (@(posedge in_clk160) disable iff (!rst_n)
		|wrce |=> wrack)
		else begin
			fail_count++;
			$error("write enable not followed by wrack");
		end

	// Ack only after an enable, and gone one cycle later
	a_wrack_pulse: assert property (@(posedge in_clk160) disable iff (!rst_n)
		wrack |-> $past(|wrce) ##1 !wrack)
		else begin
			fail_count++;
			$error("wrack is not a single pulse after a write enable");
		end

	a_rdack_follows: assert property (@(posedge in_clk160) disable iff (!rst_n)
		|rdce |=> rdack)
		else begin
			fail_count++;
			$error("read enable not followed by rdack");
		end

	a_rdack_pulse: assert property (@(posedge in_clk160) disable iff (!rst_n)
		rdack |-> $past(|rdce) ##1 !rdack)
		else begin
			fail_count++;
			$error("rdack is not a single pulse after a read enable");
		end

	//////////////////////////////////////////////////
	// Line driver
	//////////////////////////////////////////////////

	// Line follows the valid of the previous cycle, and stays off while tristated
	a_tristate_quiet: assert property (@(posedge in_clk160) disable iff (!rst_n)
		line_en == ($past(tvalid) && !tristate))
		else begin
			fail_count++;
			$error("line_en does not follow tvalid, or is high on a tristated link");
		end

endmodule

// Register block gets the bus checks, each lane the driver check
bind link_regs link_io_sva sva_regs (
	.in_clk160 (in_clk160),
	.rst_n     (rst_n),
	.wrce      (bus_wrce),
	.rdce      (bus_rdce),
	.wrack     (bus_wrack),
	.rdack     (bus_rdack),
	.tvalid    (1'b0),
	.line_en   (1'b0),
	.tristate  (1'b0)
);

bind link_tx link_io_sva sva_tx (
	.in_clk160 (in_clk160),
	.rst_n     (rst_n),
	.wrce      ('0),
	.rdce      ('0),
	.wrack     (1'b0),
	.rdack     (1'b0),
	.tvalid    (in_tvalid),
	.line_en   (line_en),
	.tristate  (ctrl.tristate)
);

/* test/link_io_tb.sv */
module link_io_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import link_io_pkg::*;

	// Tests take roughly this many cycles, the timeout leaves headroom
	localparam int test_cycles    = 1200;
	localparam int timeout_cycles = test_cycles * 5 / 2;
	localparam int global_word    = num_links * words_per_link + reg_ctrl;

	// Expected behavior of one lane's output
	localparam int mode_line   = 0;
	localparam int mode_bypass = 1;
	localparam int mode_off    = 2;
	localparam int mode_quiet  = 3;

	logic                            in_clk160;
	logic                            rst_n;
	line_word_t [num_links-1:0]      in_tdata;
	logic [num_links-1:0]            in_tvalid;
	line_word_t [num_links-1:0]      out_tdata;
	logic [num_links-1:0]            out_tvalid;
	line_word_t [num_links-1:0]      line_data;
	logic [num_links-1:0]            line_en;
	line_word_t [num_links-1:0]      line_in;
	logic [num_links-1:0]            line_in_en;
	logic [ce_width-1:0]             bus_wrce;
	logic [ce_width-1:0]             bus_rdce;
	logic [bus_width-1:0]            bus_data;
	logic [bus_width-1:0]            bus_rddata;
	logic                            bus_wrack;
	logic                            bus_rdack;

	int cycles = 0;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_start = 0;
	int sva_fails;
	int lane_mode [num_links];
	int lane_slip [num_links];
	logic [num_links-1:0] lane_tri;

	link_io_top uut (.*);

	// Line loopback
	assign line_in    = line_data;
	assign line_in_en = line_en;

	always #10 in_clk160 = ~in_clk160;

	always @(posedge in_clk160) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: the run went past %0d clock cycles", timeout_cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] mask_of(input int n);
		return 32'd1 << n;
	endfunction

	function automatic int link_word(input int l, input int off);
		return l * words_per_link + off;
	endfunction

	function automatic line_word_t rotl(input line_word_t w, input int k);
		return (w << k) | (w >> (8 - k));
	endfunction

	task automatic next_cycle();
		@(posedge in_clk160);
		#2;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic bus_write(input int word, input logic [31:0] data);
		int n;
		n = 0;
		bus_wrce = '0;
		bus_wrce[word] = 1'b1;
		bus_data = data;
		next_cycle();
		bus_wrce = '0;
		while (!bus_wrack && n < 8) begin
			next_cycle();
			n++;
		end
		if (!bus_wrack) begin
			errors++;
			$display("Write to word %0d was never acknowledged", word);
		end
		next_cycle();
		check("bus_wrack", bus_wrack, 0);
	endtask

	task automatic read_expect(input int word, input logic [31:0] exp);
		int n;
		n = 0;
		bus_rdce = '0;
		bus_rdce[word] = 1'b1;
		next_cycle();
		bus_rdce = '0;
		while (!bus_rdack && n < 8) begin
			next_cycle();
			n++;
		end
		if (!bus_rdack) begin
			errors++;
			$display("Read of word %0d was never acknowledged", word);
		end
		check($sformatf("bus_rddata (word %0d)", word), bus_rddata, exp);
		next_cycle();
		check("bus_rdack", bus_rdack, 0);
	endtask

	task automatic lanes_normal();
		for (int l = 0; l < num_links; l++) begin
			lane_mode[l] = mode_line;
			lane_slip[l] = 0;
		end
		lane_tri = '0;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, errors - test_start);
		end
		test_start = errors;
	endtask

	// Random traffic on all links, outputs checked two cycles on
	task automatic run_traffic(input int n);
		line_word_t [num_links-1:0] hist_d [$];
		logic [num_links-1:0]       hist_v [$];
		line_word_t                 d;
		logic                       v;
		for (int i = 0; i < n + 2; i++) begin
			next_cycle();
			for (int l = 0; l < num_links; l++) begin
				if (i >= 1) begin
					check($sformatf("line_en[%0d]", l), line_en[l],
						hist_v[i-1][l] && !lane_tri[l]);
					check($sformatf("line_data[%0d]", l), line_data[l], hist_d[i-1][l]);
				end
				if (i >= 2) begin
					d = hist_d[i-2][l];
					v = hist_v[i-2][l];
					case (lane_mode[l])
						mode_line: begin
							check($sformatf("out_tvalid[%0d]", l), out_tvalid[l], v);
							if (v) begin
								check($sformatf("out_tdata[%0d]", l), out_tdata[l],
									rotl(d, lane_slip[l]));
							end
						end
						mode_bypass: begin
							check($sformatf("out_tvalid[%0d]", l), out_tvalid[l], v);
							check($sformatf("out_tdata[%0d]", l), out_tdata[l], d);
						end
						mode_off: begin
							check($sformatf("out_tvalid[%0d]", l), out_tvalid[l], 0);
							check($sformatf("out_tdata[%0d]", l), out_tdata[l], 0);
						end
						default: begin
							check($sformatf("out_tvalid[%0d]", l), out_tvalid[l], 0);
						end
					endcase
				end
				if (i < n) begin
					in_tdata[l]  = $urandom;
					in_tvalid[l] = ($urandom_range(3, 0) != 0);
				end else begin
					in_tvalid[l] = 1'b0;
				end
			end
			hist_d.push_back(in_tdata);
			hist_v.push_back(in_tvalid);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic readback_test();
		int s;
		read_expect(global_word, mask_of(bit_global_enable));
		for (int l = 0; l < num_links; l++) begin
			read_expect(link_word(l, reg_ctrl), mask_of(bit_link_enable));
		end
		for (int l = 0; l < num_links; l++) begin
			s = (3 * l + 5) % 8;
			bus_write(link_word(l, reg_slip), s);
			bus_write(link_word(l, reg_ctrl), 32'h3F);
			read_expect(link_word(l, reg_slip), s);
			// Pulse bits never read back
			read_expect(link_word(l, reg_ctrl),
				32'h3F & ~mask_of(bit_delay_set) & ~mask_of(bit_reset_counters));
			read_expect(link_word(l, reg_status), s | mask_of(bit_slip_ready));
			bus_write(link_word(l, reg_slip), 0);
			bus_write(link_word(l, reg_ctrl), mask_of(bit_link_enable) | mask_of(bit_delay_set));
			read_expect(link_word(l, reg_status), mask_of(bit_slip_ready));
		end
		end_test("register readback");
	endtask

	task automatic loopback_test();
		lanes_normal();
		run_traffic(150);
		end_test("loopback");
	endtask

	task automatic bitslip_test();
		for (int l = 0; l < num_links; l++) begin
			lane_slip[l] = $urandom_range(7, 1);
			bus_write(link_word(l, reg_slip), lane_slip[l]);
			bus_write(link_word(l, reg_ctrl), mask_of(bit_link_enable) | mask_of(bit_delay_set));
			read_expect(link_word(l, reg_status), lane_slip[l] | mask_of(bit_slip_ready));
		end
		run_traffic(100);
		for (int l = 0; l < num_links; l++) begin
			bus_write(link_word(l, reg_slip), 0);
			bus_write(link_word(l, reg_ctrl), mask_of(bit_link_enable) | mask_of(bit_delay_set));
		end
		lanes_normal();
		end_test("bit-slip");
	endtask

	task automatic training_test();
		int m [num_links];
		logic [31:0] train_ctrl;
		train_ctrl = mask_of(bit_link_enable) | mask_of(bit_train_mode);
		for (int l = 0; l < num_links; l++) begin
			m[l] = 0;
			bus_write(link_word(l, reg_ctrl), train_ctrl | mask_of(bit_reset_counters));
		end
		// Mostly the training pattern, now and then a bad word
		for (int i = 0; i < 40; i++) begin
			next_cycle();
			for (int l = 0; l < num_links; l++) begin
				in_tvalid[l] = ($urandom_range(3, 0) != 0);
				in_tdata[l]  = ($urandom_range(2, 0) == 0) ? line_word_t'($urandom) : train_word;
				if (in_tvalid[l] && in_tdata[l] != train_word) begin
					m[l]++;
				end
			end
		end
		next_cycle();
		in_tvalid = '0;
		repeat (3) next_cycle();
		for (int l = 0; l < num_links; l++) begin
			read_expect(link_word(l, reg_errors), m[l]);
		end
		bus_write(link_word(0, reg_ctrl), train_ctrl | mask_of(bit_reset_counters));
		read_expect(link_word(0, reg_errors), 0);
		read_expect(link_word(1, reg_errors), m[1]);
		bus_write(global_word, mask_of(bit_global_reset_counters) | mask_of(bit_global_enable));
		for (int l = 0; l < num_links; l++) begin
			read_expect(link_word(l, reg_errors), 0);
			bus_write(link_word(l, reg_ctrl), mask_of(bit_link_enable));
		end
		end_test("training count");
	endtask

	task automatic bypass_tristate_test();
		bus_write(link_word(0, reg_ctrl), mask_of(bit_link_enable) | mask_of(bit_tristate));
		bus_write(link_word(1, reg_ctrl),
			mask_of(bit_link_enable) | mask_of(bit_tristate) | mask_of(bit_bypass));
		lane_mode[0] = mode_quiet;
		lane_mode[1] = mode_bypass;
		lane_tri     = 4'b0011;
		run_traffic(100);
		bus_write(link_word(0, reg_ctrl), mask_of(bit_link_enable));
		bus_write(link_word(1, reg_ctrl), mask_of(bit_link_enable));
		lanes_normal();
		end_test("bypass and tristate");
	endtask

	task automatic link_enable_test();
		bus_write(link_word(2, reg_ctrl), 0);
		lane_mode[2] = mode_off;
		run_traffic(80);
		bus_write(link_word(2, reg_ctrl), mask_of(bit_link_enable));
		bus_write(global_word, 0);
		for (int l = 0; l < num_links; l++) begin
			lane_mode[l] = mode_off;
		end
		run_traffic(80);
		bus_write(global_word, mask_of(bit_global_enable));
		lanes_normal();
		run_traffic(20);
		end_test("link enable");
	endtask

	//////////////////////////////////////////////////
	// Run
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'he82b));
		in_clk160 = 1'b0;
		rst_n     = 1'b0;
		in_tdata  = '0;
		in_tvalid = '0;
		bus_wrce  = '0;
		bus_rdce  = '0;
		bus_data  = '0;
		lanes_normal();
		repeat (8) @(posedge in_clk160);
		#2;
		rst_n = 1'b1;
		next_cycle();

		readback_test();
		loopback_test();
		bitslip_test();
		training_test();
		bypass_tristate_test();
		link_enable_test();

		sva_fails = uut.u_regs.sva_regs.fail_count
			+ uut.g_lane[0].u_tx.sva_tx.fail_count
			+ uut.g_lane[1].u_tx.sva_tx.fail_count
			+ uut.g_lane[2].u_tx.sva_tx.fail_count
			+ uut.g_lane[3].u_tx.sva_tx.fail_count;
		if (sva_fails != 0) begin
			errors += sva_fails;
			$display("%0d assertion failures in the bound checks", sva_fails);
		end
		$display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
common/link_io_pkg.sv
common/link_ctrl_if.sv
regs/link_regs.sv
lane/link_tx.sv
lane/link_rx.sv
src/link_io_top.sv
test/link_io_sva.sv
test/link_io_tb.sv
